// ==== source/tti_pkg.sv ====
// TTI read path package with queue word types, the buffered item and reset action codes
`default_nettype none

package tti_pkg;

  // Bytes per descriptor fit in this many bits
  localparam int unsigned DescLenWidth = 16;

  // One SDR data byte on the bus
  localparam int unsigned BitsPerByte = 8;

  // Counter covers the data bits, the T bit and the final falling edge
  localparam int unsigned BitCntWidth = $clog2(BitsPerByte + 2);

  // Word on the TX data queue
  typedef logic [BitsPerByte-1:0] tti_byte_t;

  // TX descriptor as read from the TTI descriptor queue
  typedef struct packed {
    logic [15:0]             reserved;
    logic [DescLenWidth-1:0] data_len;
  } tx_desc_t;

  // Byte tagged with the end of its descriptor
  typedef struct packed {
    tti_byte_t data;
    logic      last;
  } tx_item_t;

  // Reset action code, as delivered by RSTACT
  typedef logic [7:0] rst_action_t;

  localparam rst_action_t RstActPeripheral = 8'h01;
  localparam rst_action_t RstActEscalate   = 8'h02;

endpackage

`default_nettype wire

// ==== source/tx_descriptor_unpacker.sv ====
// TX descriptor unpacker that pulls the counted bytes from the data queue and tags the last one
`timescale 1ns/100ps
`default_nettype none

module tx_descriptor_unpacker
  import tti_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,

  // TX descriptor queue
  input  logic      tx_desc_rvalid_i,
  input  tx_desc_t  tx_desc_rdata_i,
  output logic      tx_desc_rready_o,

  // TX data queue
  input  logic      tx_queue_rvalid_i,
  input  tti_byte_t tx_queue_rdata_i,
  output logic      tx_queue_rready_o,

  // Towards the byte FIFO
  output logic      item_valid_o,
  output tx_item_t  item_o,
  input  logic      item_ready_i
);

  logic [DescLenWidth-1:0] remaining_q;
  logic                    counting;
  logic                    desc_take;
  logic                    byte_take;
  logic                    last_byte;

  // Idle whenever no bytes are left to move
  assign counting  = (remaining_q != '0);
  assign last_byte = (remaining_q == DescLenWidth'(1));

  // Descriptor accepted in the same cycle it shows up
  assign tx_desc_rready_o = ~counting & tx_desc_rvalid_i;
  assign desc_take        = tx_desc_rready_o;

  // Only pull from the queue when the FIFO can take the byte
  assign tx_queue_rready_o = counting & item_ready_i;
  assign item_valid_o      = counting & tx_queue_rvalid_i;
  assign byte_take         = item_valid_o & item_ready_i;

  always_comb begin
    item_o      = '0;
    item_o.data = tx_queue_rdata_i;
    item_o.last = last_byte;
  end

  // A zero length loads zero and leaves the block idle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      remaining_q <= '0;
    end else if (desc_take) begin
      remaining_q <= tx_desc_rdata_i.data_len;
    end else if (byte_take) begin
      remaining_q <= remaining_q - DescLenWidth'(1);
    end
  end

endmodule

`default_nettype wire

// ==== source/tx_byte_fifo.sv ====
// Byte FIFO holding tagged TX items between the unpacker and the SDR serializer
`timescale 1ns/100ps
`default_nettype none

module tx_byte_fifo
  import tti_pkg::*;
#(
  parameter int unsigned FifoDepth = 4
) (
  input  logic     clk_i,
  input  logic     rst_ni,

  input  logic     wvalid_i,
  input  tx_item_t wdata_i,
  output logic     wready_o,

  output logic     rvalid_o,
  output tx_item_t rdata_o,
  input  logic     rready_i
);

  localparam int unsigned AddrWidth = $clog2(FifoDepth);

  tx_item_t             mem_q [FifoDepth];
  logic [AddrWidth:0]   wptr_q;
  logic [AddrWidth:0]   rptr_q;
  logic                 full;
  logic                 empty;
  logic                 push;
  logic                 pop;

  // Top pointer bit tells full from empty
  assign empty = (wptr_q == rptr_q);
  assign full  = (wptr_q[AddrWidth] != rptr_q[AddrWidth]) &&
                 (wptr_q[AddrWidth-1:0] == rptr_q[AddrWidth-1:0]);

  assign wready_o = ~full;
  assign rvalid_o = ~empty;
  assign push     = wvalid_i & ~full;
  assign pop      = rready_i & ~empty;

  assign rdata_o = mem_q[rptr_q[AddrWidth-1:0]];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q <= '0;
      rptr_q <= '0;
    end else begin
      if (push) wptr_q <= wptr_q + 1'b1;
      if (pop) rptr_q <= rptr_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wptr_q[AddrWidth-1:0]] <= wdata_i;
  end

endmodule

`default_nettype wire

// ==== source/sdr_read_serializer.sv ====
// SDR read serializer that shifts data bytes and T bits onto SDA at SCL falling edges
`timescale 1ns/100ps
`default_nettype none

module sdr_read_serializer
  import tti_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,

  input  logic     xfer_en_i,
  input  logic     scl_negedge_i,

  // From the byte FIFO
  input  logic     item_valid_i,
  input  tx_item_t item_i,
  output logic     item_ready_o,

  // Bus side
  output logic     sda_o,
  output logic     sel_od_pp_o,
  output logic     tx_end_o
);

  logic                   busy_q;
  logic [BitCntWidth-1:0] bit_cnt_q;
  tti_byte_t              shift_q;
  logic                   last_q;
  logic                   sda_q;
  logic                   pp_q;
  logic                   tx_end_q;
  logic                   t_bit_next;
  logic                   t_done;
  logic                   can_start;
  logic                   start;

  // Counter value 9 means the T bit is on the bus
  assign t_bit_next = (bit_cnt_q == BitCntWidth'(BitsPerByte));
  assign t_done     = (bit_cnt_q == BitCntWidth'(BitsPerByte + 1));

  // New byte either from idle or right after a T bit of 1
  assign can_start    = ~busy_q | (t_done & ~last_q);
  assign item_ready_o = can_start & scl_negedge_i & xfer_en_i;
  assign start        = item_ready_o & item_valid_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q    <= 1'b0;
      bit_cnt_q <= '0;
      last_q    <= 1'b0;
      sda_q     <= 1'b1;
      pp_q      <= 1'b0;
      tx_end_q  <= 1'b0;
    end else begin
      tx_end_q <= 1'b0;
      if (start) begin
        busy_q    <= 1'b1;
        bit_cnt_q <= BitCntWidth'(1);
        last_q    <= item_i.last;
        sda_q     <= item_i.data[BitsPerByte-1];
        pp_q      <= 1'b1;
      end else if (busy_q && scl_negedge_i) begin
        if (t_done) begin
          // Release SDA and report the end of the read
          busy_q    <= 1'b0;
          bit_cnt_q <= '0;
          sda_q     <= 1'b1;
          tx_end_q  <= last_q;
        end else if (t_bit_next) begin
          // T bit driven open drain
          sda_q     <= ~last_q;
          pp_q      <= 1'b0;
          bit_cnt_q <= bit_cnt_q + 1'b1;
        end else begin
          sda_q     <= shift_q[BitsPerByte-1];
          bit_cnt_q <= bit_cnt_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      shift_q <= {item_i.data[BitsPerByte-2:0], 1'b0};
    end else if (busy_q && scl_negedge_i) begin
      shift_q <= {shift_q[BitsPerByte-2:0], 1'b0};
    end
  end

  assign sda_o       = sda_q;
  assign sel_od_pp_o = pp_q;
  assign tx_end_o    = tx_end_q;

endmodule

`default_nettype wire

// ==== source/target_reset_control.sv ====
// Target reset control turning reset actions and reset patterns into reset requests
`timescale 1ns/100ps
`default_nettype none

module target_reset_control
  import tti_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,

  input  rst_action_t rst_action_i,
  input  logic        rst_action_valid_i,
  input  logic        target_reset_detect_i,
  input  logic        peripheral_reset_done_i,

  output logic        peripheral_reset_o,
  output logic        escalated_reset_o
);

  logic armed_q;
  logic act_periph;
  logic act_escalate;
  logic periph_set;
  logic escalate_set;

  assign act_periph   = rst_action_valid_i & (rst_action_i == RstActPeripheral);
  assign act_escalate = rst_action_valid_i & (rst_action_i == RstActEscalate);

  // First pattern resets the peripheral, a repeated one escalates
  assign periph_set   = act_periph | (target_reset_detect_i & ~armed_q);
  assign escalate_set = act_escalate | (target_reset_detect_i & armed_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      armed_q            <= 1'b0;
      peripheral_reset_o <= 1'b0;
      escalated_reset_o  <= 1'b0;
    end else begin
      // Any reset action cancels a pending escalation
      if (rst_action_valid_i) armed_q <= 1'b0;
      else if (target_reset_detect_i) armed_q <= 1'b1;

      if (periph_set) peripheral_reset_o <= 1'b1;
      else if (peripheral_reset_done_i) peripheral_reset_o <= 1'b0;

      // Sticky until the next chip reset
      if (escalate_set) escalated_reset_o <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== source/i3c_target_read_path.sv ====
// I3C target private-read data path with the reset request logic alongside
`timescale 1ns/100ps
`default_nettype none

module i3c_target_read_path
  import tti_pkg::*;
#(
  parameter int unsigned FifoDepth = 4
) (
  input  logic        clk_i,
  input  logic        rst_ni,

  // TTI queues
  input  logic        tx_desc_rvalid_i,
  input  tx_desc_t    tx_desc_rdata_i,
  output logic        tx_desc_rready_o,
  input  logic        tx_queue_rvalid_i,
  input  tti_byte_t   tx_queue_rdata_i,
  output logic        tx_queue_rready_o,

  // Bus
  input  logic        xfer_en_i,
  input  logic        scl_negedge_i,
  output logic        sda_o,
  output logic        sel_od_pp_o,
  output logic        tx_end_o,

  // Reset handling
  input  rst_action_t rst_action_i,
  input  logic        rst_action_valid_i,
  input  logic        target_reset_detect_i,
  input  logic        peripheral_reset_done_i,
  output logic        peripheral_reset_o,
  output logic        escalated_reset_o
);

  logic     unp_valid;
  tx_item_t unp_item;
  logic     unp_ready;
  logic     ser_valid;
  tx_item_t ser_item;
  logic     ser_ready;

  tx_descriptor_unpacker u_unpacker (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .tx_desc_rvalid_i  (tx_desc_rvalid_i),
    .tx_desc_rdata_i   (tx_desc_rdata_i),
    .tx_desc_rready_o  (tx_desc_rready_o),
    .tx_queue_rvalid_i (tx_queue_rvalid_i),
    .tx_queue_rdata_i  (tx_queue_rdata_i),
    .tx_queue_rready_o (tx_queue_rready_o),
    .item_valid_o      (unp_valid),
    .item_o            (unp_item),
    .item_ready_i      (unp_ready)
  );

  tx_byte_fifo #(
    .FifoDepth (FifoDepth)
  ) u_fifo (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wvalid_i (unp_valid),
    .wdata_i  (unp_item),
    .wready_o (unp_ready),
    .rvalid_o (ser_valid),
    .rdata_o  (ser_item),
    .rready_i (ser_ready)
  );

  sdr_read_serializer u_serializer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .xfer_en_i     (xfer_en_i),
    .scl_negedge_i (scl_negedge_i),
    .item_valid_i  (ser_valid),
    .item_i        (ser_item),
    .item_ready_o  (ser_ready),
    .sda_o         (sda_o),
    .sel_od_pp_o   (sel_od_pp_o),
    .tx_end_o      (tx_end_o)
  );

  target_reset_control u_reset_ctrl (
    .clk_i                   (clk_i),
    .rst_ni                  (rst_ni),
    .rst_action_i            (rst_action_i),
    .rst_action_valid_i      (rst_action_valid_i),
    .target_reset_detect_i   (target_reset_detect_i),
    .peripheral_reset_done_i (peripheral_reset_done_i),
    .peripheral_reset_o      (peripheral_reset_o),
    .escalated_reset_o       (escalated_reset_o)
  );

endmodule

`default_nettype wire

// ==== verification/read_path_asserts.sv ====
// Concurrent checks on the read path handshakes and bus outputs
`timescale 1ns/100ps
`default_nettype none

module read_path_asserts (
  input logic clk_i,
  input logic rst_ni,
  input logic xfer_en_i,
  input logic sel_od_pp_i,
  input logic tx_end_i,
  input logic tx_queue_rready_i,
  input logic fifo_wready_i
);

  // A read ends with a single pulse
  tx_end_single: assert property (
    @(posedge clk_i) disable iff (!rst_ni) tx_end_i |=> !tx_end_i
  ) else $error("tx_end_o was high on two consecutive cycles");

  // No push-pull drive without a granted read
  od_pp_granted: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !xfer_en_i |-> !sel_od_pp_i
  ) else $error("sel_od_pp_o was high while xfer_en_i was low");

  queue_no_overflow: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !fifo_wready_i |-> !tx_queue_rready_i
  ) else $error("tx_queue_rready_o was high while the byte FIFO was full");

endmodule

bind i3c_target_read_path read_path_asserts u_read_path_asserts (
  .clk_i             (clk_i),
  .rst_ni            (rst_ni),
  .xfer_en_i         (xfer_en_i),
  .sel_od_pp_i       (sel_od_pp_o),
  .tx_end_i          (tx_end_o),
  .tx_queue_rready_i (tx_queue_rready_o),
  .fifo_wready_i     (unp_ready)
);

`default_nettype wire

// ==== verification/tb_read_path.sv ====
// Directed testbench for the I3C target read path and its reset control
`timescale 1ns/100ps
`default_nettype none

module tb_read_path;
  import tti_pkg::*;

  logic        clk_i;
  logic        rst_ni;
  logic        tx_desc_rvalid_i = 1'b0;
  tx_desc_t    tx_desc_rdata_i = '0;
  logic        tx_desc_rready_o;
  logic        tx_queue_rvalid_i = 1'b0;
  tti_byte_t   tx_queue_rdata_i = '0;
  logic        tx_queue_rready_o;
  logic        xfer_en_i;
  logic        scl_negedge_i;
  logic        sda_o;
  logic        sel_od_pp_o;
  logic        tx_end_o;
  rst_action_t rst_action_i;
  logic        rst_action_valid_i;
  logic        target_reset_detect_i;
  logic        peripheral_reset_done_i;
  logic        peripheral_reset_o;
  logic        escalated_reset_o;

  logic [31:0] lfsr_q = 32'h2d43;
  tx_desc_t    desc_src_q[$];
  tti_byte_t   byte_src_q[$];
  tti_byte_t   exp_bytes[$];
  tti_byte_t   got_bytes[$];
  logic        exp_tbits[$];
  logic        got_tbits[$];
  logic        gap_mode;
  int          desc_taken = 0;
  int          tx_end_cnt = 0;
  int          errors;
  int          checks;
  int          tests;

  i3c_target_read_path #(
    .FifoDepth (4)
  ) i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // TTI queue model that reads the handshake back once the inputs have settled
  always begin
    @(negedge clk_i);
    tx_desc_rvalid_i = (desc_src_q.size() > 0);
    if (tx_desc_rvalid_i) tx_desc_rdata_i = desc_src_q[0];
    tx_queue_rvalid_i = (byte_src_q.size() > 0) && !(gap_mode && rand_bits(1) == 0);
    if (tx_queue_rvalid_i) tx_queue_rdata_i = byte_src_q[0];
    #1;
    if (tx_desc_rvalid_i && tx_desc_rready_o) begin
      void'(desc_src_q.pop_front());
      desc_taken++;
    end
    if (tx_queue_rvalid_i && tx_queue_rready_o) void'(byte_src_q.pop_front());
  end

  always @(negedge clk_i) begin
    if (tx_end_o) tx_end_cnt++;
  end

  // Galois LFSR stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    end
    return r;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    assert (exp == act)
    else begin
      $display("ERR %s expected %0h actual %0h", name, exp, act);
      errors++;
    end
  endtask

  task automatic apply_reset();
    @(negedge clk_i);
    rst_ni = 1'b0;
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;
  endtask

  task automatic queue_desc(input int len);
    tx_desc_t d;
    d = '0;
    d.data_len = len[15:0];
    desc_src_q.push_back(d);
  endtask

  // T bit is 1 while more data follows
  task automatic queue_byte(input tti_byte_t b, input logic last);
    byte_src_q.push_back(b);
    exp_bytes.push_back(b);
    exp_tbits.push_back(~last);
  endtask

  // One SCL period with SDA sampled while SCL is high
  task automatic scl_cycle(input int half, output logic sda_s, output logic pp_s);
    @(negedge clk_i);
    scl_negedge_i = 1'b1;
    @(negedge clk_i);
    scl_negedge_i = 1'b0;
    repeat (half - 1) @(negedge clk_i);
    sda_s = sda_o;
    pp_s  = sel_od_pp_o;
    repeat (half) @(negedge clk_i);
  endtask

  // Idle SCL periods until a data bit shows up and then n bytes with their T bits
  task automatic read_bytes(input string name, input int n, input int half);
    logic      sda_s;
    logic      pp_s;
    tti_byte_t cur;
    int        idle;
    idle = 0;
    scl_cycle(half, sda_s, pp_s);
    while (!pp_s && idle < 20) begin
      check_value({name, " idle sda"}, 1, sda_s);
      idle++;
      scl_cycle(half, sda_s, pp_s);
    end
    if (!pp_s) begin
      $display("%s: timed out waiting for the first data bit on SDA", name);
      errors++;
      return;
    end
    for (int i = 0; i < n; i++) begin
      cur = '0;
      for (int j = 0; j < BitsPerByte; j++) begin
        if (i > 0 || j > 0) scl_cycle(half, sda_s, pp_s);
        check_value({name, " data push-pull"}, 1, pp_s);
        cur = {cur[BitsPerByte-2:0], sda_s};
      end
      scl_cycle(half, sda_s, pp_s);
      check_value({name, " T bit push-pull"}, 0, pp_s);
      got_bytes.push_back(cur);
      got_tbits.push_back(sda_s);
    end
  endtask

  // Release period followed by the tx_end count and the stream compare
  task automatic finish_read(input string name, input int half, input int ends,
                             input int base);
    logic sda_s;
    logic pp_s;
    int   wait_cnt;
    scl_cycle(half, sda_s, pp_s);
    check_value({name, " released sda"}, 1, sda_s);
    wait_cnt = 0;
    while (tx_end_cnt - base < ends && wait_cnt < 10) begin
      @(negedge clk_i);
      wait_cnt++;
    end
    if (tx_end_cnt - base < ends) $display("%s: timed out waiting for tx_end_o", name);
    check_value({name, " tx_end count"}, ends, tx_end_cnt - base);
    check_value({name, " byte count"}, exp_bytes.size(), got_bytes.size());
    for (int i = 0; i < exp_bytes.size() && i < got_bytes.size(); i++) begin
      check_value({name, " data"}, exp_bytes[i], got_bytes[i]);
      check_value({name, " T bit"}, exp_tbits[i], got_tbits[i]);
    end
  endtask

  task automatic open_test(output int base);
    exp_bytes.delete();
    exp_tbits.delete();
    got_bytes.delete();
    got_tbits.delete();
    base = errors;
  endtask

  task automatic close_test(input string name, input int base);
    tests++;
    xfer_en_i = 1'b0;
    $display("%s: %0d errors", name, errors - base);
  endtask

  // One-cycle pulse on the reset inputs that returns once the outputs have registered it
  task automatic reset_event(input rst_action_t act, input logic act_valid,
                             input logic detect, input logic done);
    @(negedge clk_i);
    rst_action_i            = act;
    rst_action_valid_i      = act_valid;
    target_reset_detect_i   = detect;
    peripheral_reset_done_i = done;
    @(negedge clk_i);
    rst_action_valid_i      = 1'b0;
    target_reset_detect_i   = 1'b0;
    peripheral_reset_done_i = 1'b0;
  endtask

  task automatic single_descriptor();
    int base;
    int ends;
    open_test(base);
    ends = tx_end_cnt;
    queue_desc(3);
    queue_byte(8'ha5, 1'b0);
    queue_byte(8'h3c, 1'b0);
    queue_byte(8'hf0, 1'b1);
    xfer_en_i = 1'b1;
    read_bytes("single_descriptor", 3, 4);
    finish_read("single_descriptor", 4, 1, ends);
    close_test("single_descriptor", base);
  endtask

  task automatic back_to_back_descriptors();
    int base;
    int ends;
    int len[3];
    open_test(base);
    ends = tx_end_cnt;
    for (int k = 0; k < 3; k++) begin
      len[k] = int'(rand_bits(2)) + 1;
      queue_desc(len[k]);
      for (int i = 0; i < len[k]; i++) begin
        queue_byte(tti_byte_t'(rand_bits(8)), i == len[k] - 1);
      end
    end
    xfer_en_i = 1'b1;
    for (int k = 0; k < 3; k++) read_bytes("back_to_back", len[k], 4);
    finish_read("back_to_back", 4, 3, ends);
    close_test("back_to_back", base);
  endtask

  task automatic zero_length_descriptor();
    int base;
    int ends;
    int descs;
    open_test(base);
    ends  = tx_end_cnt;
    descs = desc_taken;
    queue_desc(1);
    queue_byte(8'h81, 1'b1);
    queue_desc(0);
    queue_desc(1);
    queue_byte(8'h7e, 1'b1);
    xfer_en_i = 1'b1;
    read_bytes("zero_length", 1, 4);
    read_bytes("zero_length", 1, 4);
    finish_read("zero_length", 4, 2, ends);
    check_value("zero_length descriptors taken", 3, desc_taken - descs);
    close_test("zero_length", base);
  endtask

  // Slow bus with random holes in the data queue
  task automatic data_queue_gaps();
    int base;
    int ends;
    open_test(base);
    ends     = tx_end_cnt;
    gap_mode = 1'b1;
    queue_desc(6);
    for (int i = 0; i < 6; i++) queue_byte(tti_byte_t'(rand_bits(8)), i == 5);
    queue_desc(3);
    for (int i = 0; i < 3; i++) queue_byte(tti_byte_t'(rand_bits(8)), i == 2);
    repeat (20) @(negedge clk_i);
    check_value("queue_gaps idle sda", 1, sda_o);
    check_value("queue_gaps idle push-pull", 0, sel_od_pp_o);
    xfer_en_i = 1'b1;
    read_bytes("queue_gaps", 6, 8);
    read_bytes("queue_gaps", 3, 8);
    finish_read("queue_gaps", 8, 2, ends);
    gap_mode = 1'b0;
    close_test("queue_gaps", base);
  endtask

  task automatic reset_actions();
    int base;
    open_test(base);
    reset_event(RstActPeripheral, 1'b1, 1'b0, 1'b0);
    check_value("reset_actions peripheral set", 1, peripheral_reset_o);
    reset_event('0, 1'b0, 1'b0, 1'b1);
    check_value("reset_actions peripheral done", 0, peripheral_reset_o);
    reset_event(RstActEscalate, 1'b1, 1'b0, 1'b0);
    check_value("reset_actions escalated set", 1, escalated_reset_o);
    repeat (10) @(negedge clk_i);
    check_value("reset_actions escalated held", 1, escalated_reset_o);
    apply_reset();
    check_value("reset_actions escalated cleared", 0, escalated_reset_o);
    close_test("reset_actions", base);
  endtask

  task automatic reset_patterns();
    int base;
    open_test(base);
    reset_event('0, 1'b0, 1'b1, 1'b0);
    check_value("reset_patterns first peripheral", 1, peripheral_reset_o);
    check_value("reset_patterns first escalated", 0, escalated_reset_o);
    reset_event('0, 1'b0, 1'b0, 1'b1);
    check_value("reset_patterns done", 0, peripheral_reset_o);
    reset_event('0, 1'b0, 1'b1, 1'b0);
    check_value("reset_patterns second escalated", 1, escalated_reset_o);
    apply_reset();
    // Action between the patterns disarms escalation
    reset_event('0, 1'b0, 1'b1, 1'b0);
    reset_event(RstActPeripheral, 1'b1, 1'b0, 1'b0);
    reset_event('0, 1'b0, 1'b0, 1'b1);
    reset_event('0, 1'b0, 1'b1, 1'b0);
    check_value("reset_patterns disarmed peripheral", 1, peripheral_reset_o);
    check_value("reset_patterns disarmed escalated", 0, escalated_reset_o);
    apply_reset();
    close_test("reset_patterns", base);
  endtask

  initial begin
    rst_ni                  = 1'b0;
    xfer_en_i               = 1'b0;
    scl_negedge_i           = 1'b0;
    rst_action_i            = '0;
    rst_action_valid_i      = 1'b0;
    target_reset_detect_i   = 1'b0;
    peripheral_reset_done_i = 1'b0;
    gap_mode                = 1'b0;
    errors                  = 0;
    checks                  = 0;
    tests                   = 0;
    apply_reset();
    single_descriptor();
    back_to_back_descriptors();
    zero_length_descriptor();
    data_queue_gaps();
    reset_actions();
    reset_patterns();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
source/tti_pkg.sv
source/tx_descriptor_unpacker.sv
source/tx_byte_fifo.sv
source/sdr_read_serializer.sv
source/target_reset_control.sv
source/i3c_target_read_path.sv
verification/read_path_asserts.sv
verification/tb_read_path.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the read path testbench with Verilator
set -e -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_read_path \
  -f sources.f \
  -o tb_read_path

./obj_dir/tb_read_path | tee sim.log

if grep -q "Something failed" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
echo "Simulation finished without failures"
